// ==== sigdecode_h.f ====
+incdir+.
sigdecode_h_pkg.sv
sigdecode_h_hintsum_decode.sv
sigdecode_h_bitmap.sv
sigdecode_h_writer.sv
sigdecode_h.sv
sigdecode_h_props.sv
tb_sigdecode_h.sv

// ==== tb_sigdecode_h.sv ====
`timescale 1ns/1ps
`include "sigdecode_h_macros.svh"

module tb_sigdecode_h;
    import sigdecode_h_pkg::*;

    typedef logic [`SDH_OMEGA+`SDH_K-1:0][7:0] enc_t;

    // Each run takes about 8 x 66 cycles plus index groups, well under 600
    localparam int NUM_RUNS       = 11;
    localparam int CYCLES_PER_RUN = 600;
    localparam int WRITES_PER_RUN = `SDH_K * `SDH_WORDS_PER_POLY;

    logic                                          clk = 1'b0;
    logic                                          reset_n;
    logic                                          zeroize_i;
    logic                                          enable_i;
    enc_t                                          encoded_h_i;
    logic [`SDH_ADDR_W-1:0]                        base_addr_i;
    logic                                          mem_we_o;
    logic [`SDH_ADDR_W-1:0]                        mem_addr_o;
    logic [`SDH_COEFFS_PER_WORD*`SDH_REG_SIZE-1:0] mem_data_o;
    logic                                          done_o;
    logic                                          error_o;

    // Hint index lists per polynomial, the source of both encoding and model
    logic [7:0]             hint_idx [`SDH_K][$];
    mem_word_u              exp_data [$];
    logic [`SDH_ADDR_W-1:0] exp_addr [$];
    mem_word_u              got_data [$];
    logic [`SDH_ADDR_W-1:0] got_addr [$];
    int unsigned            lcg_state = 10391;

    sigdecode_h sigdecode_h_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .enable_i   (enable_i),
        .encoded_h_i(encoded_h_i),
        .base_addr_i(base_addr_i),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o),
        .done_o     (done_o),
        .error_o    (error_o)
    );

    always #20 clk = ~clk;

    // Writes are taken on the falling edge, half a cycle away from any change
    always @(negedge clk) begin
        if (reset_n && mem_we_o) begin
            got_data.push_back(mem_data_o);
            got_addr.push_back(mem_addr_o);
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) & 32'h7fff);
    endfunction

    // Index bytes are packed in order and each hintsum is the running count
    function automatic enc_t build_encoding();
        enc_t enc;
        int   pos;
        enc = '0;
        pos = 0;
        for (int p = 0; p < `SDH_K; p++) begin
            for (int i = 0; i < hint_idx[p].size(); i++) begin
                enc[pos] = hint_idx[p][i];
                pos++;
            end
            enc[`SDH_OMEGA + p] = 8'(pos);
        end
        return enc;
    endfunction

    // Polynomial p, word j holds hint bits 4j..4j+3 at address base + 64p + j
    function automatic void build_expected(input logic [`SDH_ADDR_W-1:0] base);
        logic [`SDH_N-1:0] bm;
        mem_word_u         w;
        exp_data.delete();
        exp_addr.delete();
        for (int p = 0; p < `SDH_K; p++) begin
            bm = '0;
            for (int i = 0; i < hint_idx[p].size(); i++)
                bm[hint_idx[p][i]] = 1'b1;
            for (int j = 0; j < `SDH_WORDS_PER_POLY; j++) begin
                w = '0;
                for (int c = 0; c < `SDH_COEFFS_PER_WORD; c++)
                    w.coeff[c][0] = bm[4*j + c];
                exp_data.push_back(w);
                exp_addr.push_back(base + `SDH_ADDR_W'(`SDH_WORDS_PER_POLY*p + j));
            end
        end
    endfunction

    // Strictly ascending indices, total kept within OMEGA
    function automatic void gen_random_lists();
        int budget;
        int cnt;
        int idx;
        budget = `SDH_OMEGA;
        for (int p = 0; p < `SDH_K; p++) begin
            hint_idx[p].delete();
            cnt = lcg_next() % 11;
            if (cnt > budget)
                cnt = budget;
            idx = lcg_next() % 8;
            for (int i = 0; (i < cnt) && (idx < `SDH_N); i++) begin
                hint_idx[p].push_back(8'(idx));
                idx = idx + 1 + lcg_next() % 40;
            end
            budget = budget - hint_idx[p].size();
        end
    endfunction

    function automatic void clear_lists();
        for (int p = 0; p < `SDH_K; p++)
            hint_idx[p].delete();
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    task automatic report_failure(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input mem_word_u got, input mem_word_u exp,
                              input logic [`SDH_ADDR_W-1:0] got_a,
                              input logic [`SDH_ADDR_W-1:0] exp_a, input int n);
        if (got_a !== exp_a)
            report_failure($sformatf("write %0d address %h, expected %h", n, got_a, exp_a));
        else if (got.flat !== exp.flat)
            report_failure($sformatf("write %0d data %h, expected %h", n, got.flat, exp.flat));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_failure($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp)
            report_failure($sformatf("%0d writes in the run, expected %0d", got, exp));
    endtask

    // ----------------------------------------
    // Run control
    // ----------------------------------------

    // Starts one run and returns on the falling edge where done is seen
    task automatic run_decode(input enc_t enc, input logic [`SDH_ADDR_W-1:0] base);
        got_data.delete();
        got_addr.delete();
        @(posedge clk);
        #2;
        encoded_h_i = enc;
        base_addr_i = base;
        enable_i    = 1'b1;
        @(posedge clk);
        #2;
        enable_i = 1'b0;
        @(negedge clk);
        // The accepted enable clears whatever error the previous run left
        check_flag(error_o, 1'b0, "error_o after enable");
        while (!done_o)
            @(negedge clk);
    endtask

    task automatic check_run(input logic exp_err, input logic with_words);
        check_count(got_data.size(), WRITES_PER_RUN);
        if (with_words) begin
            for (int i = 0; i < WRITES_PER_RUN; i++)
                check_word(got_data[i], exp_data[i], got_addr[i], exp_addr[i], i);
        end
        check_flag(error_o, exp_err, "error_o at done");
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic test_sparse_valid();
        clear_lists();
        hint_idx[0] = '{8'd0, 8'd3, 8'd17, 8'd255};
        hint_idx[2] = '{8'd1, 8'd2, 8'd4, 8'd8, 8'd16, 8'd32, 8'd64, 8'd128, 8'd200};
        hint_idx[4] = '{8'd255};
        hint_idx[5] = '{8'd9};
        hint_idx[7] = '{8'd0, 8'd100, 8'd101};
        build_expected(15'h0100);
        run_decode(build_encoding(), 15'h0100);
        check_run(1'b0, 1'b1);
    endtask

    task automatic test_no_hints();
        clear_lists();
        build_expected(15'h2345);
        run_decode('0, 15'h2345);
        check_run(1'b0, 1'b1);
    endtask

    task automatic test_hintsum_descend();
        enc_t enc;
        clear_lists();
        hint_idx[0] = '{8'd5, 8'd10};
        hint_idx[2] = '{8'd7};
        hint_idx[3] = '{8'd1, 8'd2};
        enc = build_encoding();
        // Polynomial 2 ends at 3, polynomial 3 now claims to end at 2
        enc[`SDH_OMEGA + 3] = 8'd2;
        run_decode(enc, 15'h0000);
        check_run(1'b1, 1'b0);
    endtask

    task automatic test_index_order();
        clear_lists();
        hint_idx[1] = '{8'd20, 8'd20, 8'd30};
        run_decode(build_encoding(), 15'h0040);
        check_run(1'b1, 1'b0);
        // 40 is the last lane of the first group, 39 the first of the second
        clear_lists();
        hint_idx[0] = '{8'd1, 8'd2, 8'd3, 8'd40, 8'd39, 8'd50};
        run_decode(build_encoding(), 15'h0080);
        check_run(1'b1, 1'b0);
    endtask

    task automatic test_trailing_nonzero();
        enc_t enc;
        clear_lists();
        hint_idx[0] = '{8'd11, 8'd12};
        hint_idx[6] = '{8'd99};
        enc = build_encoding();
        enc[5] = 8'h11;
        run_decode(enc, 15'h0200);
        check_run(1'b1, 1'b0);
        enc = build_encoding();
        enc[`SDH_OMEGA + `SDH_K - 1] = 8'd76;
        run_decode(enc, 15'h0300);
        check_run(1'b1, 1'b0);
    endtask

    task automatic test_random_back_to_back();
        enc_t                   enc;
        logic [`SDH_ADDR_W-1:0] base;
        // Leave an error behind so the first random run has one to clear
        clear_lists();
        hint_idx[0] = '{8'd9, 8'd9};
        run_decode(build_encoding(), 15'h0000);
        check_run(1'b1, 1'b0);
        for (int r = 0; r < 3; r++) begin
            gen_random_lists();
            enc  = build_encoding();
            base = `SDH_ADDR_W'(lcg_next());
            build_expected(base);
            run_decode(enc, base);
            check_run(1'b0, 1'b1);
        end
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial begin
        reset_n     = 1'b0;
        zeroize_i   = 1'b0;
        enable_i    = 1'b0;
        encoded_h_i = '0;
        base_addr_i = '0;
        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;
        test_sparse_valid();
        test_no_hints();
        test_hintsum_descend();
        test_index_order();
        test_trailing_nonzero();
        test_random_back_to_back();
        repeat (2) @(posedge clk);
        if (sigdecode_h_inst.props_inst.fail_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("%0d assertion failures", sigdecode_h_inst.props_inst.fail_cnt);
            $display("Errors found");
            $fatal(1, "assertions failed");
        end
    end

    initial begin
        #(NUM_RUNS * CYCLES_PER_RUN * 40 + 20000);
        $display("Timed out: the runs did not finish in time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== sigdecode_h_props.sv ====
`timescale 1ns/1ps
`include "sigdecode_h_macros.svh"

module sigdecode_h_props (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize_i,
    input  logic                       mem_we_i,
    input  logic [`SDH_ADDR_W-1:0]     mem_addr_i,
    input  logic                       done_i
);

    // Count of failed assertions, read by the testbench at the end
    int                     fail_cnt = 0;
    logic [`SDH_ADDR_W-1:0] last_addr;
    // High once the run has written its first word
    logic                   have_prev;

    // A run ends with done, so the next write starts a fresh address chain
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            have_prev <= 1'b0;
            last_addr <= '0;
        end else if (zeroize_i || done_i) begin
            have_prev <= 1'b0;
        end else if (mem_we_i) begin
            have_prev <= 1'b1;
            last_addr <= mem_addr_i;
        end
    end

    // ----------------------------------------
    // Properties
    // ----------------------------------------

    quiet_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !mem_we_i && !done_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("write strobe or done high right after reset");
        end

    done_single: assert property (@(posedge clk) disable iff (!reset_n) done_i |=> !done_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("done held for more than one cycle");
        end

    addr_step: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (mem_we_i && have_prev) |-> (mem_addr_i == `SDH_ADDR_W'(last_addr + 1'b1)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("write address did not step by one");
        end

endmodule

bind sigdecode_h sigdecode_h_props props_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize_i (zeroize_i),
    .mem_we_i  (mem_we_o),
    .mem_addr_i(mem_addr_o),
    .done_i    (done_o)
);

// ==== sigdecode_h.sv ====
`timescale 1ns/1ps
`include "sigdecode_h_macros.svh"

module sigdecode_h (
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic                                          zeroize_i,
    input  logic                                          enable_i,
    input  logic [`SDH_OMEGA+`SDH_K-1:0][7:0]             encoded_h_i,
    input  logic [`SDH_ADDR_W-1:0]                        base_addr_i,
    output logic                                          mem_we_o,
    output logic [`SDH_ADDR_W-1:0]                        mem_addr_o,
    output logic [`SDH_COEFFS_PER_WORD*`SDH_REG_SIZE-1:0] mem_data_o,
    output logic                                          done_o,
    output logic                                          error_o
);
    import sigdecode_h_pkg::*;

    // Decode to execute
    logic                            poly_start;
    logic [3:0][7:0]                 hint_grp;
    logic [3:0]                      hint_mask;
    logic                            first_grp;
    logic                            scan_go;
    logic                            scan_busy;

    // Execute to result
    logic                            coef_vld;
    logic [`SDH_COEFFS_PER_WORD-1:0] coef_bits;
    logic                            poly_last;
    logic                            order_err;

    // Decode to result
    logic                            run_start;
    logic                            hdr_err;

    mem_word_u                       mem_word;

    // The memory port takes the word as one flat bus
    assign mem_data_o = mem_word.flat;

    sigdecode_h_hintsum_decode decode_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .enable_i    (enable_i),
        .encoded_h_i (encoded_h_i),
        .scan_busy_i (scan_busy),
        .run_start_o (run_start),
        .poly_start_o(poly_start),
        .hint_grp_o  (hint_grp),
        .hint_mask_o (hint_mask),
        .first_grp_o (first_grp),
        .scan_go_o   (scan_go),
        .hdr_err_o   (hdr_err)
    );

    sigdecode_h_bitmap bitmap_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .poly_start_i(poly_start),
        .hint_grp_i  (hint_grp),
        .hint_mask_i (hint_mask),
        .first_grp_i (first_grp),
        .scan_go_i   (scan_go),
        .scan_busy_o (scan_busy),
        .coef_vld_o  (coef_vld),
        .coef_bits_o (coef_bits),
        .poly_last_o (poly_last),
        .order_err_o (order_err)
    );

    sigdecode_h_writer writer_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .run_start_i(run_start),
        .base_addr_i(base_addr_i),
        .coef_vld_i (coef_vld),
        .coef_bits_i(coef_bits),
        .poly_last_i(poly_last),
        .hdr_err_i  (hdr_err),
        .order_err_i(order_err),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_word),
        .done_o     (done_o),
        .error_o    (error_o)
    );

endmodule

// ==== sigdecode_h_writer.sv ====
`timescale 1ns/1ps
`include "sigdecode_h_macros.svh"

module sigdecode_h_writer (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  logic                            run_start_i,
    input  logic [`SDH_ADDR_W-1:0]          base_addr_i,
    input  logic                            coef_vld_i,
    input  logic [`SDH_COEFFS_PER_WORD-1:0] coef_bits_i,
    input  logic                            poly_last_i,
    input  logic                            hdr_err_i,
    input  logic                            order_err_i,
    output logic                            mem_we_o,
    output logic [`SDH_ADDR_W-1:0]          mem_addr_o,
    output sigdecode_h_pkg::mem_word_u      mem_data_o,
    output logic                            done_o,
    output logic                            error_o
);

    logic [`SDH_ADDR_W-1:0] next_addr;
    // Marks the cycle of the last write
    logic                   last_q;
    logic                   err_sticky;

    // ----------------------------------------
    // Word and address
    // ----------------------------------------

    // Each hint bit becomes a 24-bit coefficient of value 0 or 1
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            mem_addr_o <= '0;
            mem_data_o <= '0;
        end else if (coef_vld_i) begin
            mem_addr_o <= next_addr;
            for (int i = 0; i < `SDH_COEFFS_PER_WORD; i++) begin
                mem_data_o.coeff[i] <= {{(`SDH_REG_SIZE-1){1'b0}}, coef_bits_i[i]};
            end
        end
    end

    // ----------------------------------------
    // Strobes, done and error
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_we_o   <= 1'b0;
            last_q     <= 1'b0;
            done_o     <= 1'b0;
            next_addr  <= '0;
            err_sticky <= 1'b0;
            error_o    <= 1'b0;
        end else if (zeroize_i) begin
            mem_we_o   <= 1'b0;
            last_q     <= 1'b0;
            done_o     <= 1'b0;
            next_addr  <= '0;
            err_sticky <= 1'b0;
            error_o    <= 1'b0;
        end else begin
            mem_we_o <= coef_vld_i;
            last_q   <= poly_last_i;
            // Done follows the last write by one cycle
            done_o   <= last_q;

            // Addresses run consecutively from the base over all polynomials
            if (run_start_i)
                next_addr <= base_addr_i;
            else if (coef_vld_i)
                next_addr <= next_addr + 1'b1;

            // Errors gather over the run and show only from done onwards
            if (run_start_i) begin
                err_sticky <= 1'b0;
                error_o    <= 1'b0;
            end else begin
                err_sticky <= err_sticky | hdr_err_i | order_err_i;
                if (last_q)
                    error_o <= err_sticky;
            end
        end
    end

endmodule

// ==== sigdecode_h_bitmap.sv ====
`timescale 1ns/1ps
`include "sigdecode_h_macros.svh"

module sigdecode_h_bitmap (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  logic                            poly_start_i,
    input  logic [3:0][7:0]                 hint_grp_i,
    input  logic [3:0]                      hint_mask_i,
    input  logic                            first_grp_i,
    input  logic                            scan_go_i,
    output logic                            scan_busy_o,
    output logic                            coef_vld_o,
    output logic [`SDH_COEFFS_PER_WORD-1:0] coef_bits_o,
    output logic                            poly_last_o,
    output logic                            order_err_o
);

    localparam int SCAN_W = $clog2(`SDH_WORDS_PER_POLY);
    localparam int POLY_W = $clog2(`SDH_K);

    logic [`SDH_N-1:0] bitmap;
    logic [SCAN_W-1:0] scan_cnt;
    logic [POLY_W-1:0] poly_cnt;
    // Last index seen in this polynomial
    logic [7:0]        prev_idx;
    logic [7:0]        last_idx;
    logic              grp_ok;
    logic              scan_end;

    // ----------------------------------------
    // Index ordering
    // ----------------------------------------

    // Indices must rise strictly within a polynomial
    // Lane 0 of the first group has no predecessor, so any value (index 0 too) is fine
    // Valid lanes are contiguous from lane 0, so lane i valid implies lane i-1 valid
    always_comb begin
        grp_ok   = 1'b1;
        last_idx = prev_idx;
        if (hint_mask_i[0] && !first_grp_i && (hint_grp_i[0] <= prev_idx))
            grp_ok = 1'b0;
        for (int i = 1; i < 4; i++) begin
            if (hint_mask_i[i] && (hint_grp_i[i] <= hint_grp_i[i-1]))
                grp_ok = 1'b0;
        end
        // Carry the highest valid lane into the next group's check
        for (int i = 0; i < 4; i++) begin
            if (hint_mask_i[i])
                last_idx = hint_grp_i[i];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            order_err_o <= 1'b0;
            prev_idx    <= 8'h00;
        end else if (zeroize_i) begin
            order_err_o <= 1'b0;
            prev_idx    <= 8'h00;
        end else begin
            order_err_o <= !grp_ok;
            prev_idx    <= poly_start_i ? 8'h00 : last_idx;
        end
    end

    // ----------------------------------------
    // Bitmap
    // ----------------------------------------

    // Cleared at each polynomial's LOAD, one bit set per valid lane
    always_ff @(posedge clk) begin
        if (zeroize_i || poly_start_i) begin
            bitmap <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (hint_mask_i[i])
                    bitmap[hint_grp_i[i]] <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Scan
    // ----------------------------------------

    assign scan_end    = (scan_cnt == SCAN_W'(`SDH_WORDS_PER_POLY - 1));
    assign coef_vld_o  = scan_busy_o;
    // Word j carries coefficients 4j to 4j+3
    assign coef_bits_o = bitmap[{scan_cnt, 2'b00} +: `SDH_COEFFS_PER_WORD];
    assign poly_last_o = scan_busy_o && scan_end && (poly_cnt == POLY_W'(`SDH_K - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scan_busy_o <= 1'b0;
            scan_cnt    <= '0;
            poly_cnt    <= '0;
        end else if (zeroize_i) begin
            scan_busy_o <= 1'b0;
            scan_cnt    <= '0;
            poly_cnt    <= '0;
        end else if (scan_go_i) begin
            scan_busy_o <= 1'b1;
            scan_cnt    <= '0;
        end else if (scan_busy_o) begin
            scan_cnt <= scan_cnt + 1'b1;
            if (scan_end) begin
                // Every run covers all K polynomials, so the count wraps in step
                scan_busy_o <= 1'b0;
                poly_cnt    <= (poly_cnt == POLY_W'(`SDH_K - 1)) ? '0 : poly_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== sigdecode_h_hintsum_decode.sv ====
`timescale 1ns/1ps
`include "sigdecode_h_macros.svh"

module sigdecode_h_hintsum_decode (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 zeroize_i,
    input  logic                                 enable_i,
    input  logic [`SDH_OMEGA+`SDH_K-1:0][7:0]    encoded_h_i,
    input  logic                                 scan_busy_i,
    output logic                                 run_start_o,
    output logic                                 poly_start_o,
    output logic [3:0][7:0]                      hint_grp_o,
    output logic [3:0]                           hint_mask_o,
    output logic                                 first_grp_o,
    output logic                                 scan_go_o,
    output logic                                 hdr_err_o
);
    import sigdecode_h_pkg::*;

    localparam int POLY_W = $clog2(`SDH_K);

    dec_phase_e        phase;
    logic [POLY_W-1:0] poly_cnt;
    // Raw hintsum of the previous polynomial, kept for the descent check
    logic [7:0]        prev_sum;
    // End of the current polynomial's indices, never decreasing
    logic [7:0]        end_ptr;
    logic [7:0]        rd_ptr;
    logic              first_q;

    logic [7:0]        cur_sum;
    logic [7:0]        final_sum;
    logic [7:0]        clamp_sum;
    logic [7:0]        load_end;
    logic              load_empty;
    logic              last_grp;
    logic              sum_desc;
    logic              final_bad;
    logic              trail_nz;

    // ----------------------------------------
    // Hintsum decode
    // ----------------------------------------

    // Byte OMEGA+p holds the running hint count after polynomial p
    assign cur_sum   = encoded_h_i[`SDH_OMEGA + poly_cnt];
    assign final_sum = encoded_h_i[`SDH_OMEGA + `SDH_K - 1];
    assign sum_desc  = cur_sum < prev_sum;
    assign final_bad = final_sum > 8'(`SDH_OMEGA);

    // The index window is clamped to the index bytes and never moves backwards,
    // so a malformed hintsum cannot make the reader run into the hintsum bytes
    assign clamp_sum  = (cur_sum > 8'(`SDH_OMEGA)) ? 8'(`SDH_OMEGA) : cur_sum;
    assign load_end   = (clamp_sum > end_ptr) ? clamp_sum : end_ptr;
    assign load_empty = (load_end == end_ptr);

    // Last group once the next four lanes would reach the polynomial's end
    assign last_grp = (rd_ptr + 8'd4) >= end_ptr;

    // Every index byte at or above the final hintsum must be zero
    always_comb begin
        trail_nz = 1'b0;
        for (int i = 0; i < `SDH_OMEGA; i++) begin
            if ((8'(i) >= final_sum) && (encoded_h_i[i] != 8'h00))
                trail_nz = 1'b1;
        end
    end

    // ----------------------------------------
    // Index group issue
    // ----------------------------------------

    // Lanes are valid while below end_ptr, so valid lanes always start at lane 0
    always_comb begin
        logic [7:0] lane_idx;
        for (int i = 0; i < 4; i++) begin
            lane_idx       = rd_ptr + 8'(i);
            hint_mask_o[i] = (phase == READ) && (lane_idx < end_ptr);
            hint_grp_o[i]  = hint_mask_o[i] ? encoded_h_i[lane_idx] : 8'h00;
        end
    end

    assign run_start_o  = (phase == IDLE) && enable_i;
    assign poly_start_o = (phase == LOAD);
    assign first_grp_o  = (phase == READ) && first_q;

    // An empty polynomial goes straight from LOAD to the scan
    assign scan_go_o = ((phase == LOAD) && load_empty) || ((phase == READ) && last_grp);

    // Whole-string checks are raised once, on the first polynomial's LOAD
    assign hdr_err_o = (phase == LOAD) &&
                       (sum_desc || ((poly_cnt == '0) && (final_bad || trail_nz)));

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase    <= IDLE;
            poly_cnt <= '0;
            prev_sum <= 8'h00;
            end_ptr  <= 8'h00;
            rd_ptr   <= 8'h00;
            first_q  <= 1'b0;
        end else if (zeroize_i) begin
            phase    <= IDLE;
            poly_cnt <= '0;
            prev_sum <= 8'h00;
            end_ptr  <= 8'h00;
            rd_ptr   <= 8'h00;
            first_q  <= 1'b0;
        end else begin
            case (phase)
                IDLE: begin
                    if (enable_i) begin
                        poly_cnt <= '0;
                        prev_sum <= 8'h00;
                        end_ptr  <= 8'h00;
                        phase    <= LOAD;
                    end
                end
                LOAD: begin
                    // This polynomial starts where the previous one ended
                    prev_sum <= cur_sum;
                    rd_ptr   <= end_ptr;
                    end_ptr  <= load_end;
                    first_q  <= 1'b1;
                    phase    <= load_empty ? WAIT_SCAN : READ;
                end
                READ: begin
                    rd_ptr  <= rd_ptr + 8'd4;
                    first_q <= 1'b0;
                    if (last_grp)
                        phase <= WAIT_SCAN;
                end
                WAIT_SCAN: begin
                    // The bitmap raises busy on the edge after scan_go
                    if (!scan_busy_i) begin
                        if (poly_cnt == POLY_W'(`SDH_K - 1)) begin
                            phase <= FINISH;
                        end else begin
                            poly_cnt <= poly_cnt + 1'b1;
                            phase    <= LOAD;
                        end
                    end
                end
                FINISH: begin
                    phase <= IDLE;
                end
                default: begin
                    phase <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== sigdecode_h_pkg.sv ====
`include "sigdecode_h_macros.svh"

package sigdecode_h_pkg;

    // One memory word seen two ways
    // The writer fills it coefficient by coefficient, the memory port takes it flat
    typedef union packed {
        // Coefficient 0 sits in the low bits
        logic [`SDH_COEFFS_PER_WORD-1:0][`SDH_REG_SIZE-1:0] coeff;
        logic [`SDH_COEFFS_PER_WORD*`SDH_REG_SIZE-1:0]      flat;
    } mem_word_u;

    // Decoder phases
    // LOAD reads one hintsum, READ issues index groups,
    // WAIT_SCAN holds until the bitmap has been written out
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        READ,
        WAIT_SCAN,
        FINISH
    } dec_phase_e;

endpackage

// ==== sigdecode_h_macros.svh ====
`ifndef SIGDECODE_H_MACROS_SVH
`define SIGDECODE_H_MACROS_SVH

// ----------------------------------------
// ML-DSA h field layout
// ----------------------------------------

// Maximum number of non-zero hints over all polynomials
`define SDH_OMEGA 75

// Number of polynomials in the hint vector
`define SDH_K 8

// Coefficients per polynomial
`define SDH_N 256

// ----------------------------------------
// Memory word layout
// ----------------------------------------

// Width of one coefficient as stored in memory
`define SDH_REG_SIZE 24

// Memory address width
`define SDH_ADDR_W 15

// Coefficients packed into one memory word
`define SDH_COEFFS_PER_WORD 4

// One polynomial fills N/4 consecutive addresses
`define SDH_WORDS_PER_POLY (`SDH_N / `SDH_COEFFS_PER_WORD)

`endif
